// File: fir_assertions.sv
module fir_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic awvalid_i,
  input logic awready_i,
  input logic wvalid_i,
  input logic wready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic y_valid_i,
  input logic busy_i,
  input logic start_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of assertion failures in this run
  int unsigned fail_count = 0;

  // High from an accepted start until its result pulse
  logic run_open_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_open_q <= 1'b0;
    end else if (start_i) begin
      run_open_q <= 1'b1;
    end else if (y_valid_i) begin
      run_open_q <= 1'b0;
    end
  end

  // A valid stays up until the cycle of its handshake
  property valid_held(valid, ready);
    @(posedge clk_i) disable iff (!rst_ni) valid && !ready |=> valid;
  endproperty

  aw_hold_a: assert property (valid_held(awvalid_i, awready_i))
    else begin
      fail_count++;
      $error("AW valid dropped before handshake");
    end
  w_hold_a: assert property (valid_held(wvalid_i, wready_i))
    else begin
      fail_count++;
      $error("W valid dropped before handshake");
    end
  b_hold_a: assert property (valid_held(bvalid_i, bready_i))
    else begin
      fail_count++;
      $error("B valid dropped before handshake");
    end
  ar_hold_a: assert property (valid_held(arvalid_i, arready_i))
    else begin
      fail_count++;
      $error("AR valid dropped before handshake");
    end
  r_hold_a: assert property (valid_held(rvalid_i, rready_i))
    else begin
      fail_count++;
      $error("R valid dropped before handshake");
    end

  // Result strobe is one cycle wide and ends a busy run
  y_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    y_valid_i |-> $past(busy_i) ##1 !y_valid_i)
    else begin
      fail_count++;
      $error("y_valid not a single pulse at the end of a busy run");
    end

  // New start only after the previous run delivered its result
  no_start_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !run_open_q)
    else begin
      fail_count++;
      $error("run started while engine busy");
    end

endmodule

bind fir_top fir_assertions u_assertions (
  .clk_i, .rst_ni,
  .awvalid_i(s_axil_awvalid_i), .awready_i(s_axil_awready_o),
  .wvalid_i(s_axil_wvalid_i), .wready_i(s_axil_wready_o),
  .bvalid_i(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
  .arvalid_i(s_axil_arvalid_i), .arready_i(s_axil_arready_o),
  .rvalid_i(s_axil_rvalid_o), .rready_i(s_axil_rready_i),
  .y_valid_i(y_valid_o), .busy_i(busy_o), .start_i(start)
);

// File: fir_axil_regs.sv
module fir_axil_regs #(
  parameter int AddrWidth = 6
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [fir_pkg::AxilAddrWidth-1:0]   s_axil_awaddr_i,
  input  logic                                s_axil_awvalid_i,
  output logic                                s_axil_awready_o,
  input  logic [fir_pkg::AxilDataWidth-1:0]   s_axil_wdata_i,
  input  logic [fir_pkg::AxilDataWidth/8-1:0] s_axil_wstrb_i,
  input  logic                                s_axil_wvalid_i,
  output logic                                s_axil_wready_o,
  output logic [1:0]                          s_axil_bresp_o,
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_bready_i,
  input  logic [fir_pkg::AxilAddrWidth-1:0]   s_axil_araddr_i,
  input  logic                                s_axil_arvalid_i,
  output logic                                s_axil_arready_o,
  output logic [fir_pkg::AxilDataWidth-1:0]   s_axil_rdata_o,
  output logic [1:0]                          s_axil_rresp_o,
  output logic                                s_axil_rvalid_o,
  input  logic                                s_axil_rready_i,
  input  logic                                busy_i,
  input  logic [fir_pkg::AccWidth-1:0]        y_i,
  input  logic                                y_valid_i,
  output logic [AddrWidth:0]                  num_taps_o,
  output logic                                coeff_we_o,
  output logic [AddrWidth-1:0]                coeff_waddr_o,
  output logic [fir_pkg::SampleWidth-1:0]     coeff_wdata_o
);

  import fir_pkg::*;

  localparam int MaxTaps = 2 ** AddrWidth;
  localparam int NtWidth = AddrWidth + 1;

  logic                     aw_ready_q;
  logic                     bvalid_q;
  logic [1:0]               bresp_q;
  logic                     ar_ready_q;
  logic                     rvalid_q;
  logic [1:0]               rresp_q;
  logic [AxilDataWidth-1:0] rdata_q;
  logic [NtWidth-1:0]       num_taps_q;
  logic                     res_avail_q;
  logic [AccWidth-1:0]      last_y_q;
  logic                     coeff_we_q;
  logic [AddrWidth-1:0]     coeff_waddr_q;
  logic [SampleWidth-1:0]   coeff_wdata_q;
  logic                     wr_hs;
  logic                     rd_hs;
  logic                     ctrl_hit;
  logic                     coeff_hit;
  logic                     taps_ok;
  logic [NtWidth-1:0]       new_taps;
  logic [AxilAddrWidth-1:0] coeff_off;
  logic [AxilDataWidth-1:0] rd_mux;
  logic [1:0]               rd_resp;

  assign wr_hs = aw_ready_q & s_axil_awvalid_i & s_axil_wvalid_i;
  assign rd_hs = ar_ready_q & s_axil_arvalid_i;

  // Write decode
  assign new_taps  = s_axil_wdata_i[NtWidth-1:0];
  assign taps_ok   = (new_taps != '0) && (new_taps <= MaxTaps);
  assign ctrl_hit  = (s_axil_awaddr_i == RegCtrl);
  assign coeff_off = s_axil_awaddr_i - RegCoeffBase;
  assign coeff_hit = (s_axil_awaddr_i >= RegCoeffBase) && (coeff_off[1:0] == 2'b00) &&
                     (coeff_off[AxilAddrWidth-1:2] < MaxTaps);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      bresp_q    <= RespOkay;
      num_taps_q <= NtWidth'(1);
      coeff_we_q <= 1'b0;
    end else begin
      // AW and W taken together, one pulse, never with a B pending
      aw_ready_q <= s_axil_awvalid_i & s_axil_wvalid_i & ~aw_ready_q & ~bvalid_q;
      coeff_we_q <= wr_hs & coeff_hit & (&s_axil_wstrb_i[1:0]);
      if (bvalid_q && s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= RespOkay;
        if (ctrl_hit && taps_ok) begin
          if (s_axil_wstrb_i[0]) begin
            num_taps_q <= new_taps;
          end
        end else if (!coeff_hit) begin
          bresp_q <= RespSlverr;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      coeff_waddr_q <= coeff_off[AddrWidth+1:2];
      coeff_wdata_q <= s_axil_wdata_i[SampleWidth-1:0];
    end
  end

  // Read mux
  always_comb begin
    rd_mux  = '0;
    rd_resp = RespOkay;
    case (s_axil_araddr_i)
      RegCtrl: rd_mux[NtWidth-1:0] = num_taps_q;
      RegStatus: begin
        rd_mux[0] = busy_i;
        rd_mux[1] = res_avail_q;
      end
      RegResult: rd_mux = last_y_q;
      default: rd_resp = RespSlverr;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_ready_q  <= 1'b0;
      rvalid_q    <= 1'b0;
      res_avail_q <= 1'b0;
      last_y_q    <= '0;
    end else begin
      ar_ready_q <= s_axil_arvalid_i & ~ar_ready_q & ~rvalid_q;
      if (rvalid_q && s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end
      if (y_valid_i) begin
        last_y_q <= y_i;
      end
      // A fresh result wins over a clearing read
      if (y_valid_i) begin
        res_avail_q <= 1'b1;
      end else if (rd_hs && s_axil_araddr_i == RegResult) begin
        res_avail_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      rdata_q <= rd_mux;
      rresp_q <= rd_resp;
    end
  end

  assign s_axil_awready_o = aw_ready_q;
  assign s_axil_wready_o  = aw_ready_q;
  assign s_axil_bresp_o   = bresp_q;
  assign s_axil_bvalid_o  = bvalid_q;
  assign s_axil_arready_o = ar_ready_q;
  assign s_axil_rdata_o   = rdata_q;
  assign s_axil_rresp_o   = rresp_q;
  assign s_axil_rvalid_o  = rvalid_q;

  assign num_taps_o    = num_taps_q;
  assign coeff_we_o    = coeff_we_q;
  assign coeff_waddr_o = coeff_waddr_q;
  assign coeff_wdata_o = coeff_wdata_q;

endmodule

// File: fir_dpram.sv
module fir_dpram #(
  parameter int AddrWidth = 6
) (
  input  logic                            clk_i,
  input  logic                            we_i,
  input  logic [AddrWidth-1:0]            waddr_i,
  input  logic [fir_pkg::SampleWidth-1:0] wdata_i,
  input  logic                            re_i,
  input  logic [AddrWidth-1:0]            raddr_i,
  output logic [fir_pkg::SampleWidth-1:0] rdata_o
);

  localparam int Depth = 2 ** AddrWidth;

  // Cleared at start, so history not yet written reads as zero
  logic [fir_pkg::SampleWidth-1:0] mem [Depth] = '{default: '0};

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // Registered read, data valid one cycle after re_i
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// File: fir_mac_engine.sv
module fir_mac_engine #(
  parameter int AddrWidth = 6
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic [AddrWidth-1:0]            newest_addr_i,
  input  logic [AddrWidth:0]              num_taps_i,
  output logic                            sample_re_o,
  output logic [AddrWidth-1:0]            sample_raddr_o,
  input  logic [fir_pkg::SampleWidth-1:0] sample_rdata_i,
  output logic                            coeff_re_o,
  output logic [AddrWidth-1:0]            coeff_raddr_o,
  input  logic [fir_pkg::SampleWidth-1:0] coeff_rdata_i,
  output logic                            busy_o,
  output logic [fir_pkg::AccWidth-1:0]    y_o,
  output logic                            y_valid_o
);

  import fir_pkg::*;

  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StRead = 2'd1;
  localparam logic [1:0] StDrain = 2'd2;
  localparam logic [1:0] StOutput = 2'd3;

  logic [1:0]                  state_q;
  logic [AddrWidth:0]          num_taps_q;
  logic [AddrWidth:0]          tap_q;
  logic [AddrWidth-1:0]        sample_addr_q;
  logic                        rd_valid_q;
  logic                        last_tap;
  logic signed [AccWidth-1:0]  product;
  logic signed [AccWidth-1:0]  acc_q;

  assign last_tap = (tap_q == num_taps_q - 1'b1);

  // Full-width signed product, the sum wraps at AccWidth
  assign product = $signed(sample_rdata_i) * $signed(coeff_rdata_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      rd_valid_q <= 1'b0;
      y_valid_o  <= 1'b0;
    end else begin
      // RAM data lands one cycle after each read
      rd_valid_q <= (state_q == StRead);
      y_valid_o  <= (state_q == StOutput);
      case (state_q)
        StIdle: begin
          if (start_i) begin
            state_q <= StRead;
          end
        end
        StRead: begin
          if (last_tap) begin
            state_q <= StDrain;
          end
        end
        StDrain: begin
          state_q <= StOutput;
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && start_i) begin
      num_taps_q    <= num_taps_i;
      tap_q         <= '0;
      sample_addr_q <= newest_addr_i;
      acc_q         <= '0;
    end else if (state_q == StRead) begin
      tap_q         <= tap_q + 1'b1;
      // Walk back through history, wrapping below slot 0
      sample_addr_q <= sample_addr_q - 1'b1;
    end
    if (rd_valid_q) begin
      acc_q <= acc_q + product;
    end
    // Result register, last pipeline stage
    if (state_q == StOutput) begin
      y_o <= acc_q;
    end
  end

  assign sample_re_o    = (state_q == StRead);
  assign sample_raddr_o = sample_addr_q;
  assign coeff_re_o     = (state_q == StRead);
  assign coeff_raddr_o  = tap_q[AddrWidth-1:0];

  // Held through the result pulse
  assign busy_o = (state_q != StIdle) | y_valid_o;

endmodule

// File: fir_pkg.sv
package fir_pkg;

  // Datapath widths
  localparam int SampleWidth = 16;
  localparam int AccWidth = 32;

  // AXI4-Lite bus
  localparam int AxilAddrWidth = 12;
  localparam int AxilDataWidth = 32;

  // Register map offsets
  localparam logic [AxilAddrWidth-1:0] RegCtrl = 12'h000;
  localparam logic [AxilAddrWidth-1:0] RegStatus = 12'h004;
  localparam logic [AxilAddrWidth-1:0] RegResult = 12'h008;
  // Coefficient k sits at RegCoeffBase + 4*k
  localparam logic [AxilAddrWidth-1:0] RegCoeffBase = 12'h400;

  // AXI response codes
  localparam logic [1:0] RespOkay = 2'b00;
  localparam logic [1:0] RespSlverr = 2'b10;

endpackage

// File: fir_sample_capture.sv
module fir_sample_capture #(
  parameter int AddrWidth = 6
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            sample_strobe_i,
  input  logic [fir_pkg::SampleWidth-1:0] sample_i,
  input  logic                            busy_i,
  output logic                            sample_we_o,
  output logic [AddrWidth-1:0]            sample_waddr_o,
  output logic [fir_pkg::SampleWidth-1:0] sample_wdata_o,
  output logic                            start_o,
  output logic [AddrWidth-1:0]            newest_addr_o
);

  logic                 strobe_q;
  logic                 accept;
  logic [AddrWidth-1:0] wr_ptr_q;

  // Rising strobe edge, dropped while a run is busy
  assign accept = sample_strobe_i & ~strobe_q & ~busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strobe_q <= 1'b0;
      wr_ptr_q <= '0;
    end else begin
      strobe_q <= sample_strobe_i;
      // Pointer wraps naturally at the ring depth
      if (accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  assign sample_we_o    = accept;
  assign sample_waddr_o = wr_ptr_q;
  assign sample_wdata_o = sample_i;

  // Engine starts from the slot just written
  assign start_o       = accept;
  assign newest_addr_o = wr_ptr_q;

endmodule

// File: fir_tb.sv
module fir_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fir_pkg::*;

  localparam int AddrWidth = 6;
  localparam int MaxTaps = 2 ** AddrWidth;
  // Longest test is the full-depth run at roughly 6000 cycles
  localparam int CycleLimit = 20000;
  localparam logic [AxilAddrWidth-1:0] UnmappedWrAddr = 12'h00c;
  localparam logic [AxilAddrWidth-1:0] UnmappedRdAddr = 12'h010;

  logic                     clk;
  logic                     rst_n;
  logic                     sample_strobe;
  logic [SampleWidth-1:0]   sample;
  logic [AccWidth-1:0]      y;
  logic                     y_valid;
  logic                     busy;
  logic [AxilAddrWidth-1:0] awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [AxilDataWidth-1:0] wdata;
  logic [3:0]               wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [AxilAddrWidth-1:0] araddr;
  logic                     arvalid;
  logic                     arready;
  logic [AxilDataWidth-1:0] rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  // Model state with the newest sample at the front of the history
  shortint             coef [MaxTaps];
  shortint             hist [$];
  logic [AccWidth-1:0] expected_q [$];
  logic [AccWidth-1:0] last_expected;
  int                  taps;
  int                  errors;
  int                  checks;
  int                  results;
  int                  sent;
  int                  cycles;
  int                  seed;

  fir_top #(.AddrWidth(AddrWidth)) dut_i (
    .clk_i(clk), .rst_ni(rst_n),
    .sample_strobe_i(sample_strobe), .sample_i(sample),
    .y_o(y), .y_valid_o(y_valid), .busy_o(busy),
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
    .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
    .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
    .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Wrapped sum of coef[k] times the sample k steps back
  function automatic logic [AccWidth-1:0] fir_reference(input int n);
    int acc;
    int s;
    int k;
    acc = 0;
    for (k = 0; k < n; k++) begin
      s = (k < hist.size()) ? int'(hist[k]) : 0;
      acc += int'(coef[k]) * s;
    end
    return acc;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic axil_write(input logic [AxilAddrWidth-1:0] addr,
                            input logic [AxilDataWidth-1:0] data, output logic [1:0] resp);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    check_value(wready, 1'b1, "W ready together with AW ready");
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [AxilAddrWidth-1:0] addr,
                           output logic [AxilDataWidth-1:0] data, output logic [1:0] resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic write_coeff(input int k, input logic [SampleWidth-1:0] value);
    logic [1:0] resp;
    axil_write(RegCoeffBase + AxilAddrWidth'(4 * k), {16'h0000, value}, resp);
    check_value(resp, RespOkay, "coefficient write response");
    coef[k] = shortint'(value);
  endtask

  task automatic set_taps(input int n);
    logic [1:0] resp;
    axil_write(RegCtrl, 32'(n), resp);
    check_value(resp, RespOkay, "tap count write response");
    taps = n;
  endtask

  // One strobe edge while idle so the model records it
  task automatic send_sample(input logic [SampleWidth-1:0] value);
    do @(posedge clk); while (busy);
    sample_strobe <= 1'b1;
    sample        <= value;
    hist.push_front(shortint'(value));
    last_expected = fir_reference(taps);
    expected_q.push_back(last_expected);
    sent++;
    @(posedge clk);
    sample_strobe <= 1'b0;
  endtask

  task automatic wait_results();
    do @(posedge clk); while (busy || expected_q.size() != 0);
  endtask

  always @(posedge clk) begin
    if (rst_n && y_valid) begin
      results++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("unexpected result at %0d ns with no sample pending", $time);
      end else begin
        check_value(y, expected_q.pop_front(), "filter output");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", CycleLimit);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    logic [AxilDataWidth-1:0] rd;
    logic [1:0]               resp;
    int                       i;
    seed          = 32'h00a4_d45f;
    taps          = 1;
    rst_n         = 1'b0;
    sample_strobe = 1'b0;
    sample        = '0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Single unit tap passes samples through
    axil_read(RegCtrl, rd, resp);
    check_value(rd, 32'd1, "tap count after reset");
    check_value(resp, RespOkay, "control read response");
    write_coeff(0, 16'h0001);
    send_sample(16'h1234);
    send_sample(16'h8001);
    send_sample(16'hffff);
    send_sample(16'h7fff);
    wait_results();

    // Eight random taps while early history is still partly zero
    for (i = 0; i < 8; i++) begin
      write_coeff(i, 16'($random(seed)));
    end
    set_taps(8);
    for (i = 0; i < 40; i++) begin
      send_sample(16'($random(seed)));
    end
    wait_results();

    // Full depth so the ring buffer wraps
    for (i = 0; i < MaxTaps; i++) begin
      write_coeff(i, 16'($random(seed)));
    end
    set_taps(MaxTaps);
    for (i = 0; i < MaxTaps + 16; i++) begin
      send_sample(16'($random(seed)));
    end
    wait_results();

    // Edge during a run is dropped
    send_sample(16'($random(seed)));
    do @(posedge clk); while (!busy);
    repeat (2) @(posedge clk);
    sample_strobe <= 1'b1;
    sample        <= 16'h5a5a;
    @(posedge clk);
    sample_strobe <= 1'b0;
    wait_results();
    repeat (10) @(posedge clk);
    check_value(results, sent, "result count after dropped edge");
    send_sample(16'($random(seed)));
    wait_results();

    // Error responses leave the tap count alone
    axil_write(RegCtrl, 32'd0, resp);
    check_value(resp, RespSlverr, "zero tap count response");
    axil_write(RegCtrl, 32'd65, resp);
    check_value(resp, RespSlverr, "oversized tap count response");
    axil_write(UnmappedWrAddr, 32'd1, resp);
    check_value(resp, RespSlverr, "unmapped write response");
    axil_read(UnmappedRdAddr, rd, resp);
    check_value(resp, RespSlverr, "unmapped read response");
    axil_read(RegCtrl, rd, resp);
    check_value(rd, 32'(MaxTaps), "tap count after rejected writes");

    // Sticky flag set by a result and cleared by reading it
    send_sample(16'($random(seed)));
    wait_results();
    axil_read(RegStatus, rd, resp);
    check_value(rd, 32'h2, "status with result available");
    axil_read(RegResult, rd, resp);
    check_value(rd, last_expected, "last result register");
    axil_read(RegStatus, rd, resp);
    check_value(rd, 32'h0, "status after result read");

    check_value(results, sent, "final result count");
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut_i.u_assertions.fail_count);
    if (errors == 0 && dut_i.u_assertions.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: fir_top.sv
module fir_top #(
  parameter int AddrWidth = 6
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                sample_strobe_i,
  input  logic [fir_pkg::SampleWidth-1:0]     sample_i,
  output logic [fir_pkg::AccWidth-1:0]        y_o,
  output logic                                y_valid_o,
  output logic                                busy_o,
  input  logic [fir_pkg::AxilAddrWidth-1:0]   s_axil_awaddr_i,
  input  logic                                s_axil_awvalid_i,
  output logic                                s_axil_awready_o,
  input  logic [fir_pkg::AxilDataWidth-1:0]   s_axil_wdata_i,
  input  logic [fir_pkg::AxilDataWidth/8-1:0] s_axil_wstrb_i,
  input  logic                                s_axil_wvalid_i,
  output logic                                s_axil_wready_o,
  output logic [1:0]                          s_axil_bresp_o,
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_bready_i,
  input  logic [fir_pkg::AxilAddrWidth-1:0]   s_axil_araddr_i,
  input  logic                                s_axil_arvalid_i,
  output logic                                s_axil_arready_o,
  output logic [fir_pkg::AxilDataWidth-1:0]   s_axil_rdata_o,
  output logic [1:0]                          s_axil_rresp_o,
  output logic                                s_axil_rvalid_o,
  input  logic                                s_axil_rready_i
);

  import fir_pkg::*;

  logic                   sample_we;
  logic [AddrWidth-1:0]   sample_waddr;
  logic [SampleWidth-1:0] sample_wdata;
  logic                   sample_re;
  logic [AddrWidth-1:0]   sample_raddr;
  logic [SampleWidth-1:0] sample_rdata;
  logic                   coeff_we;
  logic [AddrWidth-1:0]   coeff_waddr;
  logic [SampleWidth-1:0] coeff_wdata;
  logic                   coeff_re;
  logic [AddrWidth-1:0]   coeff_raddr;
  logic [SampleWidth-1:0] coeff_rdata;
  logic                   start;
  logic [AddrWidth-1:0]   newest_addr;
  logic [AddrWidth:0]     num_taps;

  fir_axil_regs #(.AddrWidth(AddrWidth)) u_regs (
    .clk_i, .rst_ni,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .busy_i(busy_o), .y_i(y_o), .y_valid_i(y_valid_o),
    .num_taps_o(num_taps),
    .coeff_we_o(coeff_we), .coeff_waddr_o(coeff_waddr), .coeff_wdata_o(coeff_wdata)
  );

  // Stage 1, sample capture into the ring buffer
  fir_sample_capture #(.AddrWidth(AddrWidth)) u_capture (
    .clk_i, .rst_ni, .sample_strobe_i, .sample_i,
    .busy_i(busy_o),
    .sample_we_o(sample_we), .sample_waddr_o(sample_waddr), .sample_wdata_o(sample_wdata),
    .start_o(start), .newest_addr_o(newest_addr)
  );

  fir_dpram #(.AddrWidth(AddrWidth)) u_sample_ram (
    .clk_i, .we_i(sample_we), .waddr_i(sample_waddr), .wdata_i(sample_wdata),
    .re_i(sample_re), .raddr_i(sample_raddr), .rdata_o(sample_rdata)
  );

  fir_dpram #(.AddrWidth(AddrWidth)) u_coeff_ram (
    .clk_i, .we_i(coeff_we), .waddr_i(coeff_waddr), .wdata_i(coeff_wdata),
    .re_i(coeff_re), .raddr_i(coeff_raddr), .rdata_o(coeff_rdata)
  );

  // Stages 2 and 3, MAC and result register
  fir_mac_engine #(.AddrWidth(AddrWidth)) u_engine (
    .clk_i, .rst_ni,
    .start_i(start), .newest_addr_i(newest_addr), .num_taps_i(num_taps),
    .sample_re_o(sample_re), .sample_raddr_o(sample_raddr), .sample_rdata_i(sample_rdata),
    .coeff_re_o(coeff_re), .coeff_raddr_o(coeff_raddr), .coeff_rdata_i(coeff_rdata),
    .busy_o, .y_o, .y_valid_o
  );

endmodule

// File: flist.f
fir_pkg.sv
fir_dpram.sv
fir_sample_capture.sv
fir_mac_engine.sv
fir_axil_regs.sv
fir_top.sv
fir_assertions.sv
fir_tb.sv
